/* common/simd_alu_consts.svh */
// Shared widths, APB register map and command word layout for the SIMD ALU
// peripheral. Included by the package and by every RTL file that decodes
// bus words or slices the 64-bit operand.

`ifndef SIMD_ALU_CONSTS_SVH
`define SIMD_ALU_CONSTS_SVH

// Data widths
`define SIMD_ALU_DATA_W   64
`define APB_DATA_W        32
`define APB_ADDR_W        8

// Register map, byte offsets
`define REG_OPA_LO        8'h00
`define REG_OPA_HI        8'h04
`define REG_OPB_LO        8'h08
`define REG_OPB_HI        8'h0C
`define REG_CMD           8'h10
`define REG_RES_LO        8'h14
`define REG_RES_HI        8'h18
`define REG_STATUS        8'h1C

// Command word fields
`define CMD_OP_LSB        0
`define CMD_OP_W          5
`define CMD_VEW_LSB       8
`define CMD_VEW_W         2
`define CMD_VXRM_LSB      12
`define CMD_VXRM_W        2

// Status word, bit 0 is busy
`define STATUS_VXSAT_LSB  8

`endif

/* common/simd_alu_pkg.sv */
// Types shared by the SIMD ALU peripheral: bus words, packed operands,
// command field encodings and the control state machine states.
// Referenced by scoped name from the RTL.

`include "simd_alu_consts.svh"

package simd_alu_pkg;

  // One operand or result with packed lanes
  typedef logic [`SIMD_ALU_DATA_W-1:0] elem_vec_t;

  typedef logic [`APB_DATA_W-1:0] apb_data_t;
  typedef logic [`APB_ADDR_W-1:0] apb_addr_t;

  // One saturation flag per byte of the operand
  typedef logic [`SIMD_ALU_DATA_W/8-1:0] byte_flags_t;

  // 0 nearest up, 1 nearest even, 2 down, 3 odd
  typedef logic [`CMD_VXRM_W-1:0] vxrm_t;

  typedef enum logic [`CMD_VEW_W-1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  // Codes above VMAX are rejected by the control FSM
  typedef enum logic [`CMD_OP_W-1:0] {
    VADD, VSUB, VRSUB,
    VSADDU, VSADD, VSSUBU, VSSUB,
    VAADDU, VAADD,
    VAND, VOR, VXOR,
    VSLL, VSRL, VSRA,
    VMINU, VMIN, VMAXU, VMAX
  } alu_op_e;

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    WRITEBACK
  } ctrl_state_e;

endpackage

/* alu/simd_arith.sv */
// Lane-wise integer arithmetic of the SIMD ALU: wrapping and saturating
// add and subtract, averaging add with fixed-point rounding, and min/max.
// Purely combinational, the lane width is picked by vew_i.

`timescale 1ns/100ps
`include "simd_alu_consts.svh"

module simd_arith (
  input  simd_alu_pkg::elem_vec_t   opa_i,
  input  simd_alu_pkg::elem_vec_t   opb_i,
  input  simd_alu_pkg::alu_op_e     op_i,
  input  simd_alu_pkg::vew_e        vew_i,
  input  simd_alu_pkg::vxrm_t       vxrm_i,
  output simd_alu_pkg::elem_vec_t   res_o,
  output simd_alu_pkg::byte_flags_t sat_o
);

  logic is_signed;

  // One full-word result per element width
  wire simd_alu_pkg::elem_vec_t   res_w [4];
  wire simd_alu_pkg::byte_flags_t sat_w [4];

  assign is_signed = op_i inside {simd_alu_pkg::VSADD, simd_alu_pkg::VSSUB,
                                  simd_alu_pkg::VAADD, simd_alu_pkg::VMIN,
                                  simd_alu_pkg::VMAX};

  for (genvar g = 0; g < 4; g++) begin : g_width
    localparam int W  = 8 << g;
    localparam int NL = `SIMD_ALU_DATA_W / W;

    for (genvar l = 0; l < NL; l++) begin : g_lane
      logic [W-1:0] a, b, res, smax, smin;
      logic [W:0]   a_x, b_x, sum, dif, rdif;
      logic         sat, less, rnd;

      assign a = opa_i[l*W +: W];
      assign b = opb_i[l*W +: W];

      // One guard bit, sign or zero extended
      assign a_x  = {is_signed & a[W-1], a};
      assign b_x  = {is_signed & b[W-1], b};
      assign sum  = b_x + a_x;
      assign dif  = b_x - a_x;
      assign rdif = a_x - b_x;
      assign less = $signed(b_x) < $signed(a_x);

      assign smax = {1'b0, {(W-1){1'b1}}};
      assign smin = {1'b1, {(W-1){1'b0}}};

      // Rounding increment from dropped bit 0 and kept bit 1
      always_comb begin
        case (vxrm_i)
          2'd0:    rnd = sum[0];
          2'd1:    rnd = sum[0] & sum[1];
          2'd2:    rnd = 1'b0;
          default: rnd = sum[0] & ~sum[1];
        endcase
      end

      always_comb begin
        res = '0;
        sat = 1'b0;
        case (op_i)
          simd_alu_pkg::VADD:  res = sum[W-1:0];
          simd_alu_pkg::VSUB:  res = dif[W-1:0];
          simd_alu_pkg::VRSUB: res = rdif[W-1:0];
          simd_alu_pkg::VSADDU: begin
            sat = sum[W];
            res = sat ? '1 : sum[W-1:0];
          end
          simd_alu_pkg::VSADD: begin
            sat = sum[W] ^ sum[W-1];
            res = sat ? (sum[W] ? smin : smax) : sum[W-1:0];
          end
          simd_alu_pkg::VSSUBU: begin
            // Borrow out means the true result is negative
            sat = dif[W];
            res = sat ? '0 : dif[W-1:0];
          end
          simd_alu_pkg::VSSUB: begin
            sat = dif[W] ^ dif[W-1];
            res = sat ? (dif[W] ? smin : smax) : dif[W-1:0];
          end
          simd_alu_pkg::VAADDU,
          simd_alu_pkg::VAADD: res = sum[W:1] + W'(rnd);
          simd_alu_pkg::VMINU,
          simd_alu_pkg::VMIN:  res = less ? b : a;
          simd_alu_pkg::VMAXU,
          simd_alu_pkg::VMAX:  res = less ? a : b;
          default: begin
            res = '0;
            sat = 1'b0;
          end
        endcase
      end

      assign res_w[g][l*W +: W] = res;
      // Lane flag copied into every byte of the lane
      assign sat_w[g][l*(W/8) +: W/8] = {(W/8){sat}};
    end
  end

  assign res_o = res_w[vew_i];
  assign sat_o = sat_w[vew_i];

endmodule

/* alu/simd_shift_logic.sv */
// Bitwise logic and lane-wise shifts of the SIMD ALU. Each lane of B is
// shifted by the low bits of the matching lane of A.

`timescale 1ns/100ps
`include "simd_alu_consts.svh"

module simd_shift_logic (
  input  simd_alu_pkg::elem_vec_t opa_i,
  input  simd_alu_pkg::elem_vec_t opb_i,
  input  simd_alu_pkg::alu_op_e   op_i,
  input  simd_alu_pkg::vew_e      vew_i,
  output simd_alu_pkg::elem_vec_t res_o
);

  wire simd_alu_pkg::elem_vec_t shift_w [4];

  for (genvar g = 0; g < 4; g++) begin : g_width
    localparam int W  = 8 << g;
    localparam int SW = $clog2(W);
    localparam int NL = `SIMD_ALU_DATA_W / W;

    for (genvar l = 0; l < NL; l++) begin : g_lane
      logic [W-1:0]  b, sll, srl, sra;
      logic [SW-1:0] sh;

      assign b  = opb_i[l*W +: W];
      assign sh = opa_i[l*W +: SW];

      assign sll = b << sh;
      assign srl = b >> sh;
      // Sign fill
      assign sra = $signed(b) >>> sh;

      assign shift_w[g][l*W +: W] = (op_i == simd_alu_pkg::VSLL) ? sll :
                                    (op_i == simd_alu_pkg::VSRA) ? sra : srl;
    end
  end

  always_comb begin
    case (op_i)
      simd_alu_pkg::VAND: res_o = opa_i & opb_i;
      simd_alu_pkg::VOR:  res_o = opa_i | opb_i;
      simd_alu_pkg::VXOR: res_o = opa_i ^ opb_i;
      simd_alu_pkg::VSLL,
      simd_alu_pkg::VSRL,
      simd_alu_pkg::VSRA: res_o = shift_w[vew_i];
      default:            res_o = '0;
    endcase
  end

endmodule

/* alu/simd_alu_core.sv */
// Execute stage of the SIMD ALU. Routes the command to the arithmetic or
// the shift/logic unit and captures the result and saturation flags in
// the pipeline register while exec_i is high.

`timescale 1ns/100ps

module simd_alu_core (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      exec_i,
  input  simd_alu_pkg::elem_vec_t   opa_i,
  input  simd_alu_pkg::elem_vec_t   opb_i,
  input  simd_alu_pkg::alu_op_e     op_i,
  input  simd_alu_pkg::vew_e        vew_i,
  input  simd_alu_pkg::vxrm_t       vxrm_i,
  output simd_alu_pkg::elem_vec_t   pipe_res_o,
  output simd_alu_pkg::byte_flags_t pipe_sat_o
);

  simd_alu_pkg::elem_vec_t   arith_res, sl_res, res_d;
  simd_alu_pkg::byte_flags_t arith_sat, sat_d;
  logic                      is_shift_logic;

  simd_arith i_arith (
    .opa_i  (opa_i),
    .opb_i  (opb_i),
    .op_i   (op_i),
    .vew_i  (vew_i),
    .vxrm_i (vxrm_i),
    .res_o  (arith_res),
    .sat_o  (arith_sat)
  );

  simd_shift_logic i_shift_logic (
    .opa_i (opa_i),
    .opb_i (opb_i),
    .op_i  (op_i),
    .vew_i (vew_i),
    .res_o (sl_res)
  );

  // Operation class select
  assign is_shift_logic = op_i inside {simd_alu_pkg::VAND, simd_alu_pkg::VOR,
                                       simd_alu_pkg::VXOR, simd_alu_pkg::VSLL,
                                       simd_alu_pkg::VSRL, simd_alu_pkg::VSRA};

  assign res_d = is_shift_logic ? sl_res : arith_res;
  assign sat_d = is_shift_logic ? '0 : arith_sat;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pipe_res_o <= '0;
      pipe_sat_o <= '0;
    end else if (exec_i) begin
      pipe_res_o <= res_d;
      pipe_sat_o <= sat_d;
    end
  end

endmodule

/* verilog/apb_alu_regs.sv */
// APB slave register file of the SIMD ALU. Holds the operand halves, the
// command fields and the result, answers reads and flags bad accesses.
// Operand, command and result accesses wait while the ALU is busy.

`timescale 1ns/100ps
`include "simd_alu_consts.svh"

module apb_alu_regs (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  simd_alu_pkg::apb_addr_t   paddr_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  simd_alu_pkg::apb_data_t   pwdata_i,
  output simd_alu_pkg::apb_data_t   prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  input  logic                      busy_i,
  input  logic                      wb_i,
  input  logic                      cmd_err_i,
  input  simd_alu_pkg::elem_vec_t   pipe_res_i,
  input  simd_alu_pkg::byte_flags_t pipe_sat_i,
  output simd_alu_pkg::elem_vec_t   opa_o,
  output simd_alu_pkg::elem_vec_t   opb_o,
  output simd_alu_pkg::alu_op_e     op_o,
  output simd_alu_pkg::vew_e        vew_o,
  output simd_alu_pkg::vxrm_t       vxrm_o,
  output logic                      cmd_wr_o
);

  logic hit_opa_lo, hit_opa_hi, hit_opb_lo, hit_opb_hi;
  logic hit_cmd, hit_res_lo, hit_res_hi, hit_status;
  logic addr_mapped, waits_on_busy, bad_access, access, wr_en;

  simd_alu_pkg::elem_vec_t   opa_q, opb_q, res_q;
  simd_alu_pkg::byte_flags_t vxsat_q;
  simd_alu_pkg::alu_op_e     op_q;
  simd_alu_pkg::vew_e        vew_q;
  simd_alu_pkg::vxrm_t       vxrm_q;

  //////////////////////////////////////////////////
  // Address decode and handshake
  //////////////////////////////////////////////////

  assign hit_opa_lo = (paddr_i == `REG_OPA_LO);
  assign hit_opa_hi = (paddr_i == `REG_OPA_HI);
  assign hit_opb_lo = (paddr_i == `REG_OPB_LO);
  assign hit_opb_hi = (paddr_i == `REG_OPB_HI);
  assign hit_cmd    = (paddr_i == `REG_CMD);
  assign hit_res_lo = (paddr_i == `REG_RES_LO);
  assign hit_res_hi = (paddr_i == `REG_RES_HI);
  assign hit_status = (paddr_i == `REG_STATUS);

  assign waits_on_busy = hit_opa_lo | hit_opa_hi | hit_opb_lo | hit_opb_hi |
                         hit_cmd | hit_res_lo | hit_res_hi;
  assign addr_mapped   = waits_on_busy | hit_status;

  // Status stays readable while a command runs
  assign pready_o = ~(busy_i & psel_i & waits_on_busy);

  assign bad_access = ~addr_mapped |
                      (pwrite_i & (hit_res_lo | hit_res_hi | hit_status)) |
                      (pwrite_i & hit_cmd & cmd_err_i);

  assign access    = psel_i & penable_i & pready_o;
  assign pslverr_o = access & bad_access;
  assign wr_en     = access & pwrite_i & ~bad_access;
  assign cmd_wr_o  = wr_en & hit_cmd;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      opa_q   <= '0;
      opb_q   <= '0;
      res_q   <= '0;
      vxsat_q <= '0;
      op_q    <= simd_alu_pkg::VADD;
      vew_q   <= simd_alu_pkg::EW8;
      vxrm_q  <= '0;
    end else begin
      if (wr_en & hit_opa_lo) opa_q[`APB_DATA_W-1:0] <= pwdata_i;
      if (wr_en & hit_opa_hi) opa_q[`SIMD_ALU_DATA_W-1:`APB_DATA_W] <= pwdata_i;
      if (wr_en & hit_opb_lo) opb_q[`APB_DATA_W-1:0] <= pwdata_i;
      if (wr_en & hit_opb_hi) opb_q[`SIMD_ALU_DATA_W-1:`APB_DATA_W] <= pwdata_i;
      if (cmd_wr_o) begin
        op_q   <= simd_alu_pkg::alu_op_e'(pwdata_i[`CMD_OP_LSB +: `CMD_OP_W]);
        vew_q  <= simd_alu_pkg::vew_e'(pwdata_i[`CMD_VEW_LSB +: `CMD_VEW_W]);
        vxrm_q <= pwdata_i[`CMD_VXRM_LSB +: `CMD_VXRM_W];
      end
      // Writeback from the execute stage
      if (wb_i) begin
        res_q   <= pipe_res_i;
        vxsat_q <= pipe_sat_i;
      end
    end
  end

  // Read mux
  always_comb begin
    prdata_o = '0;
    case (paddr_i)
      `REG_OPA_LO: prdata_o = opa_q[`APB_DATA_W-1:0];
      `REG_OPA_HI: prdata_o = opa_q[`SIMD_ALU_DATA_W-1:`APB_DATA_W];
      `REG_OPB_LO: prdata_o = opb_q[`APB_DATA_W-1:0];
      `REG_OPB_HI: prdata_o = opb_q[`SIMD_ALU_DATA_W-1:`APB_DATA_W];
      `REG_CMD: begin
        prdata_o[`CMD_OP_LSB +: `CMD_OP_W]     = op_q;
        prdata_o[`CMD_VEW_LSB +: `CMD_VEW_W]   = vew_q;
        prdata_o[`CMD_VXRM_LSB +: `CMD_VXRM_W] = vxrm_q;
      end
      `REG_RES_LO: prdata_o = res_q[`APB_DATA_W-1:0];
      `REG_RES_HI: prdata_o = res_q[`SIMD_ALU_DATA_W-1:`APB_DATA_W];
      `REG_STATUS: begin
        prdata_o[0] = busy_i;
        prdata_o[`STATUS_VXSAT_LSB +: `SIMD_ALU_DATA_W/8] = vxsat_q;
      end
      default: prdata_o = '0;
    endcase
  end

  assign opa_o  = opa_q;
  assign opb_o  = opb_q;
  assign op_o   = op_q;
  assign vew_o  = vew_q;
  assign vxrm_o = vxrm_q;

endmodule

/* verilog/alu_ctrl_fsm.sv */
// Command FSM of the SIMD ALU. Rejects illegal operation codes and, after a
// legal command write, runs one EXEC and one WRITEBACK cycle.

`timescale 1ns/100ps
`include "simd_alu_consts.svh"

module alu_ctrl_fsm (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 cmd_wr_i,
  input  logic [`CMD_OP_W-1:0] cmd_op_i,
  output logic                 cmd_err_o,
  output logic                 exec_o,
  output logic                 wb_o,
  output logic                 busy_o
);

  // Highest legal operation code
  localparam logic [`CMD_OP_W-1:0] LastOp = simd_alu_pkg::VMAX;

  simd_alu_pkg::ctrl_state_e state_q, state_d;

  assign cmd_err_o = (cmd_op_i > LastOp);

  //////////////////////////////////////////////////
  // State sequencing
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      simd_alu_pkg::IDLE: begin
        if (cmd_wr_i) begin
          state_d = simd_alu_pkg::EXEC;
        end
      end
      // Fixed latency, no handshake with the core
      simd_alu_pkg::EXEC:      state_d = simd_alu_pkg::WRITEBACK;
      simd_alu_pkg::WRITEBACK: state_d = simd_alu_pkg::IDLE;
      default:                 state_d = simd_alu_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= simd_alu_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Datapath steering
  assign exec_o = (state_q == simd_alu_pkg::EXEC);
  assign wb_o   = (state_q == simd_alu_pkg::WRITEBACK);
  assign busy_o = exec_o | wb_o;

endmodule

/* verilog/simd_alu_top.sv */
// Top level of the APB SIMD ALU peripheral. Connects the register file,
// the command FSM and the two-stage ALU core.

`timescale 1ns/100ps
`include "simd_alu_consts.svh"

module simd_alu_top (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  simd_alu_pkg::apb_addr_t paddr_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  simd_alu_pkg::apb_data_t pwdata_i,
  output simd_alu_pkg::apb_data_t prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o
);

  simd_alu_pkg::elem_vec_t   opa, opb, pipe_res;
  simd_alu_pkg::byte_flags_t pipe_sat;
  simd_alu_pkg::alu_op_e     op;
  simd_alu_pkg::vew_e        vew;
  simd_alu_pkg::vxrm_t       vxrm;
  logic                      cmd_wr, cmd_err, exec, wb, busy;

  apb_alu_regs i_regs (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .paddr_i    (paddr_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .busy_i     (busy),
    .wb_i       (wb),
    .cmd_err_i  (cmd_err),
    .pipe_res_i (pipe_res),
    .pipe_sat_i (pipe_sat),
    .opa_o      (opa),
    .opb_o      (opb),
    .op_o       (op),
    .vew_o      (vew),
    .vxrm_o     (vxrm),
    .cmd_wr_o   (cmd_wr)
  );

  // Legality is judged on the word being written
  alu_ctrl_fsm i_fsm (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .cmd_wr_i  (cmd_wr),
    .cmd_op_i  (pwdata_i[`CMD_OP_LSB +: `CMD_OP_W]),
    .cmd_err_o (cmd_err),
    .exec_o    (exec),
    .wb_o      (wb),
    .busy_o    (busy)
  );

  simd_alu_core i_core (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .exec_i     (exec),
    .opa_i      (opa),
    .opb_i      (opb),
    .op_i       (op),
    .vew_i      (vew),
    .vxrm_i     (vxrm),
    .pipe_res_o (pipe_res),
    .pipe_sat_o (pipe_sat)
  );

endmodule

/* sim/simd_alu_properties.sv */
// Concurrent checks on the APB answer and the busy window of the SIMD ALU.
// Bound into simd_alu_top; failures report through $error.

`timescale 1ns/100ps

module simd_alu_properties (
  input logic clk_i,
  input logic reset_i,
  input logic pready_i,
  input logic pslverr_i,
  input logic busy_i
);

  // Error response only together with ready
  assert property (@(posedge clk_i) disable iff (reset_i) pslverr_i |-> pready_i)
    else $error("pslverr high while pready is low");

  // Busy covers EXEC and WRITEBACK only
  assert property (@(posedge clk_i) disable iff (reset_i)
                   ($past(busy_i) && $past(busy_i, 2)) |-> !busy_i)
    else $error("busy held for more than two cycles");

  assert property (@(posedge clk_i) $past(reset_i) |-> pready_i)
    else $error("pready low in the cycle after reset");

endmodule

bind simd_alu_top simd_alu_properties i_props (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .pready_i  (pready_o),
  .pslverr_i (pslverr_o),
  .busy_i    (busy)
);

/* sim/simd_alu_tb.sv */
// Testbench for the APB SIMD ALU peripheral. Drives APB transfers on the
// falling clock edge, draws operands from an LFSR and checks every result
// and saturation field against a lane model kept in this file.

`timescale 1ns/100ps
`include "simd_alu_consts.svh"

module simd_alu_tb;

  localparam int CLK_PERIOD    = 20;
  localparam int READY_TIMEOUT = 20;
  localparam int NUM_RANDOM    = 300;

  logic                    clk, reset;
  simd_alu_pkg::apb_addr_t paddr;
  logic                    psel, penable, pwrite;
  simd_alu_pkg::apb_data_t pwdata, prdata;
  logic                    pready, pslverr;

  logic [31:0] lfsr;
  logic [63:0] last_res;
  int          errors;
  int          checks;

  simd_alu_top i_dut (
    .clk_i     (clk),
    .reset_i   (reset),
    .paddr_i   (paddr),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Random source and lane model
  //////////////////////////////////////////////////

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic logic [63:0] lane_mask(input logic [1:0] ew);
    return (ew == 2'd3) ? '1 : ((64'd1 << (8 << ew)) - 64'd1);
  endfunction

  // Same lane value everywhere, or only in even lanes
  function automatic logic [63:0] fill_lanes(input logic [1:0] ew, input logic [63:0] v,
                                             input logic even_only);
    logic [63:0] res;
    int          w;
    w = 8 << ew;
    res = '0;
    for (int l = 0; l < 64 / w; l++) begin
      if (!even_only || (l % 2 == 0)) res = res | ((v & lane_mask(ew)) << (l * w));
    end
    return res;
  endfunction

  function automatic logic signed [65:0] extend(input logic [63:0] v, input logic [63:0] mask,
                                                input logic neg);
    return {2'b00, v} | (neg ? ~{2'b00, mask} : 66'd0);
  endfunction

  function automatic logic [63:0] model_op(input logic [4:0] op, input logic [1:0] ew,
                                           input logic [1:0] rm, input logic [63:0] a,
                                           input logic [63:0] b, output logic [7:0] sat);
    logic [63:0]        mask, la, lb, res;
    logic signed [65:0] xa, xb, xbs, r, hi, lo;
    logic               sgn, s;
    int                 w, sh;
    w = 8 << ew;
    mask = lane_mask(ew);
    res = '0;
    sat = '0;
    sgn = op inside {simd_alu_pkg::VSADD, simd_alu_pkg::VSSUB, simd_alu_pkg::VAADD,
                     simd_alu_pkg::VMIN, simd_alu_pkg::VMAX};
    hi = sgn ? {3'b000, mask[63:1]} : {2'b00, mask};
    lo = sgn ? -hi - 66'sd1 : 66'sd0;
    for (int l = 0; l < 64 / w; l++) begin
      la = (a >> (l * w)) & mask;
      lb = (b >> (l * w)) & mask;
      xa = extend(la, mask, sgn & la[w-1]);
      xb = extend(lb, mask, sgn & lb[w-1]);
      xbs = extend(lb, mask, lb[w-1]);
      sh = int'(la[5:0]) & (w - 1);
      s = 1'b0;
      r = '0;
      case (op)
        simd_alu_pkg::VADD:  r = xb + xa;
        simd_alu_pkg::VSUB:  r = xb - xa;
        simd_alu_pkg::VRSUB: r = xa - xb;
        simd_alu_pkg::VSADDU, simd_alu_pkg::VSADD,
        simd_alu_pkg::VSSUBU, simd_alu_pkg::VSSUB: begin
          r = (op inside {simd_alu_pkg::VSADDU, simd_alu_pkg::VSADD}) ? xb + xa : xb - xa;
          s = (r > hi) || (r < lo);
          if (r > hi) r = hi;
          if (r < lo) r = lo;
        end
        simd_alu_pkg::VAADDU, simd_alu_pkg::VAADD: begin
          r = xb + xa;
          case (rm)
            // Half goes up
            2'd0:    r = (r + 66'sd1) >>> 1;
            // Half goes to the even neighbor
            2'd1:    r = (r >>> 1) + ((r[0] && r[1]) ? 66'sd1 : 66'sd0);
            2'd2:    r = r >>> 1;
            // Dropped one is jammed into bit 0
            default: r = (r >>> 1) | {65'd0, r[0]};
          endcase
        end
        simd_alu_pkg::VAND:  r = xa & xb;
        simd_alu_pkg::VOR:   r = xa | xb;
        simd_alu_pkg::VXOR:  r = xa ^ xb;
        simd_alu_pkg::VSLL:  r = {2'b00, lb << sh};
        simd_alu_pkg::VSRL:  r = {2'b00, lb >> sh};
        simd_alu_pkg::VSRA:  r = xbs >>> sh;
        simd_alu_pkg::VMINU, simd_alu_pkg::VMIN: r = (xb < xa) ? xb : xa;
        simd_alu_pkg::VMAXU, simd_alu_pkg::VMAX: r = (xb < xa) ? xa : xb;
        default: r = '0;
      endcase
      res = res | ((r[63:0] & mask) << (l * w));
      if (s) sat = sat | (8'((16'd1 << (w / 8)) - 16'd1) << (l * w / 8));
    end
    return res;
  endfunction

  //////////////////////////////////////////////////
  // APB driver
  //////////////////////////////////////////////////

  task automatic end_run();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  // Samples a quarter period after the falling edge, before the completing edge
  task automatic access_phase(output logic [31:0] rdata, output logic err, output int waits);
    waits = 0;
    rdata = '0;
    err   = 1'b0;
    #(CLK_PERIOD / 4);
    while (!pready && waits < READY_TIMEOUT) begin
      waits++;
      @(negedge clk);
      #(CLK_PERIOD / 4);
    end
    if (!pready) begin
      $display("Timeout: pready stayed low for %0d cycles at address %h", waits, paddr);
      errors++;
      end_run();
    end else begin
      rdata = prdata;
      err = pslverr;
      @(posedge clk);
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused_rd;
    int          waits;
    @(negedge clk);
    paddr   = addr;
    pwrite  = 1'b1;
    pwdata  = data;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    access_phase(unused_rd, err, waits);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err,
                          output int waits);
    @(negedge clk);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    access_phase(data, err, waits);
  endtask

  task automatic apb_idle();
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Command sequences
  //////////////////////////////////////////////////

  task automatic load_cmd(input logic [4:0] op, input logic [1:0] ew, input logic [1:0] rm,
                          input logic [63:0] a, input logic [63:0] b);
    logic [31:0] cmd;
    logic        err, bad;
    cmd = '0;
    cmd[`CMD_OP_LSB +: `CMD_OP_W]     = op;
    cmd[`CMD_VEW_LSB +: `CMD_VEW_W]   = ew;
    cmd[`CMD_VXRM_LSB +: `CMD_VXRM_W] = rm;
    apb_write(`REG_OPA_LO, a[31:0], bad);
    apb_write(`REG_OPA_HI, a[63:32], err);
    bad = bad | err;
    apb_write(`REG_OPB_LO, b[31:0], err);
    bad = bad | err;
    apb_write(`REG_OPB_HI, b[63:32], err);
    bad = bad | err;
    apb_write(`REG_CMD, cmd, err);
    checks++;
    if (bad | err) begin
      $display("Operand or command write for op %0d was rejected", op);
      errors++;
    end
  endtask

  task automatic read_result(output logic [63:0] res, output logic [31:0] status);
    logic e0, e1, e2;
    int   waits;
    apb_read(`REG_RES_LO, res[31:0], e0, waits);
    apb_read(`REG_RES_HI, res[63:32], e1, waits);
    apb_read(`REG_STATUS, status, e2, waits);
    checks++;
    if (e0 | e1 | e2) begin
      $display("A result or status read returned an error response");
      errors++;
    end
  endtask

  task automatic run_op(input logic [4:0] op, input logic [1:0] ew, input logic [1:0] rm,
                        input logic [63:0] a, input logic [63:0] b);
    logic [63:0] exp_res, got_res;
    logic [7:0]  exp_sat;
    logic [31:0] status;
    exp_res = model_op(op, ew, rm, a, b, exp_sat);
    load_cmd(op, ew, rm, a, b);
    read_result(got_res, status);
    last_res = exp_res;
    checks += 2;
    if (got_res !== exp_res) begin
      $display("FAILED RESULT got %h expected %h (op %0d ew %0d rm %0d a %h b %h)",
               got_res, exp_res, op, ew, rm, a, b);
      errors++;
    end
    if (status[`STATUS_VXSAT_LSB +: 8] !== exp_sat) begin
      $display("FAILED VXSAT got %h expected %h (op %0d ew %0d a %h b %h)",
               status[`STATUS_VXSAT_LSB +: 8], exp_sat, op, ew, a, b);
      errors++;
    end
  endtask

  // Odd lanes of A stay zero so only even lanes hit the limits
  task automatic run_edges(input logic [1:0] ew);
    logic [63:0] ones, smax, smin;
    ones = lane_mask(ew);
    smax = ones >> 1;
    smin = smax + 64'd1;
    run_op(simd_alu_pkg::VSADDU, ew, 2'd0,
           fill_lanes(ew, ones, 1'b1), fill_lanes(ew, 64'd1, 1'b0));
    run_op(simd_alu_pkg::VSADD, ew, 2'd0,
           fill_lanes(ew, smax, 1'b1), fill_lanes(ew, 64'd1, 1'b0));
    run_op(simd_alu_pkg::VSADD, ew, 2'd0,
           fill_lanes(ew, smin, 1'b1), fill_lanes(ew, ones, 1'b0));
    run_op(simd_alu_pkg::VSSUBU, ew, 2'd0,
           fill_lanes(ew, 64'd1, 1'b1), fill_lanes(ew, 64'd0, 1'b0));
    run_op(simd_alu_pkg::VSSUB, ew, 2'd0,
           fill_lanes(ew, 64'd1, 1'b1), fill_lanes(ew, smin, 1'b0));
    run_op(simd_alu_pkg::VSSUB, ew, 2'd0,
           fill_lanes(ew, ones, 1'b1), fill_lanes(ew, smax, 1'b0));
    // Sums ending in 01 and 11 tell all four modes apart
    for (int rm = 0; rm < 4; rm++) begin
      run_op(simd_alu_pkg::VAADDU, ew, 2'(rm),
             fill_lanes(ew, 64'd1, 1'b1), fill_lanes(ew, 64'd4, 1'b0));
      run_op(simd_alu_pkg::VAADDU, ew, 2'(rm),
             fill_lanes(ew, 64'd1, 1'b1), fill_lanes(ew, ones, 1'b0));
      run_op(simd_alu_pkg::VAADD, ew, 2'(rm),
             fill_lanes(ew, ones, 1'b1), fill_lanes(ew, smin, 1'b0));
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [63:0] a, b, r, got, exp_res;
    logic [31:0] rd, status;
    logic [7:0]  exp_sat;
    logic        err;
    int          waits;
    lfsr     = 32'h4a7b;
    errors   = 0;
    checks   = 0;
    last_res = '0;
    reset    = 1'b1;
    paddr    = '0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    pwdata   = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Registers come out of reset cleared
    read_result(got, status);
    checks += 2;
    if (got !== 64'd0) begin
      $display("FAILED RESULT got %h expected %h after reset", got, 64'd0);
      errors++;
    end
    if (status !== 32'd0) begin
      $display("FAILED STATUS got %h expected %h after reset", status, 32'd0);
      errors++;
    end

    // Op code in bits 4:0, width in 6:5, rounding mode in 8:7
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rand_bits(9, r);
      rand_bits(64, a);
      rand_bits(64, b);
      run_op(5'(r[4:0] % 5'd19), r[6:5], r[8:7], a, b);
    end

    for (int ew = 0; ew < 4; ew++) begin
      run_edges(2'(ew));
    end

    // Result read right behind a command waits for writeback
    rand_bits(64, a);
    rand_bits(64, b);
    exp_res = model_op(simd_alu_pkg::VADD, 2'd1, 2'd0, a, b, exp_sat);
    load_cmd(simd_alu_pkg::VADD, 2'd1, 2'd0, a, b);
    apb_read(`REG_RES_LO, rd, err, waits);
    checks += 3;
    if (waits == 0) begin
      $display("RESULT read right after a command completed without a wait state");
      errors++;
    end
    if (rd !== exp_res[31:0]) begin
      $display("FAILED RES_LO got %h expected %h", rd, exp_res[31:0]);
      errors++;
    end
    if (err !== 1'b0) begin
      $display("RESULT read after a wait state returned an error response");
      errors++;
    end

    // Status answers at once and shows busy
    exp_res = model_op(simd_alu_pkg::VXOR, 2'd0, 2'd0, a, b, exp_sat);
    load_cmd(simd_alu_pkg::VXOR, 2'd0, 2'd0, a, b);
    apb_read(`REG_STATUS, rd, err, waits);
    checks += 3;
    if (rd[0] !== 1'b1) begin
      $display("FAILED STATUS busy got %h expected %h", rd[0], 1'b1);
      errors++;
    end
    if (err !== 1'b0) begin
      $display("STATUS read while busy returned an error response");
      errors++;
    end
    if (waits != 0) begin
      $display("STATUS read was held with %0d wait states while busy", waits);
      errors++;
    end
    read_result(got, status);
    last_res = exp_res;
    checks++;
    if (got !== exp_res) begin
      $display("FAILED RESULT got %h expected %h after busy window", got, exp_res);
      errors++;
    end

    // Bad accesses answer with an error and change nothing
    apb_write(`REG_CMD, 32'd25, err);
    checks++;
    if (err !== 1'b1) begin
      $display("FAILED pslverr got %h expected %h for illegal op code", err, 1'b1);
      errors++;
    end
    apb_read(8'h20, rd, err, waits);
    checks++;
    if (err !== 1'b1) begin
      $display("FAILED pslverr got %h expected %h for unmapped address", err, 1'b1);
      errors++;
    end
    apb_write(`REG_RES_LO, 32'h5a5a_0f0f, err);
    checks++;
    if (err !== 1'b1) begin
      $display("FAILED pslverr got %h expected %h for RES_LO write", err, 1'b1);
      errors++;
    end
    read_result(got, status);
    checks += 2;
    if (got !== last_res) begin
      $display("FAILED RESULT got %h expected %h after bad accesses", got, last_res);
      errors++;
    end
    if (status[0] !== 1'b0) begin
      $display("FAILED STATUS busy got %h expected %h after bad accesses", status[0], 1'b0);
      errors++;
    end

    apb_idle();
    end_run();
  end

endmodule

/* project.f */
+incdir+common
common/simd_alu_pkg.sv
alu/simd_arith.sv
alu/simd_shift_logic.sv
alu/simd_alu_core.sv
verilog/apb_alu_regs.sv
verilog/alu_ctrl_fsm.sv
verilog/simd_alu_top.sv
sim/simd_alu_properties.sv
sim/simd_alu_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := simd_alu_tb
FILELIST   := project.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Checks failed
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
